// File: mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// ******************************
// Buffer sizing
// ******************************

// Number of buffer addresses, also the free list depth
`define MEM_NUMADDR 16

// Address width, log2 of MEM_NUMADDR
`define MEM_BITADDR 4

`define MEM_WIDTH   32                  // Data word width

// Free count must hold 0 up to MEM_NUMADDR inclusive
`define MEM_BITCNT  (`MEM_BITADDR + 1)

`endif

// File: mem_types_pkg.sv
`include "mem_settings.svh"

package mem_types_pkg;

  // Buffer address, one free list entry
  typedef logic [`MEM_BITADDR-1:0] addr_t;

  typedef logic [`MEM_WIDTH-1:0]   data_t;   // Stored payload word

  // Number of free addresses, also the back-pressure threshold
  typedef logic [`MEM_BITCNT-1:0]  count_t;

endpackage

// File: mem_ctrl_pkg.sv
package mem_ctrl_pkg;

  // Allocator sequence after reset
  typedef enum logic {
    ST_FILL,                            // Loading addresses into the free list
    ST_RUN                              // Allocate and dequeue accepted
  } alloc_state_e;

endpackage

// File: free_list_alloc.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module free_list_alloc (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  ma_write,
  input  logic                  dq_vld,
  input  mem_types_pkg::addr_t  dq_adr,
  input  mem_types_pkg::count_t bp_thr,
  output logic                  ready,
  output logic                  ma_bp,
  output logic                  take,
  output mem_types_pkg::addr_t  ma_adr
);

  import mem_types_pkg::*;
  import mem_ctrl_pkg::*;

  alloc_state_e state;
  addr_t        fl_mem [`MEM_NUMADDR];  // Circular list of free addresses
  addr_t        head;                   // Next address to hand out
  addr_t        tail;                   // Slot for the next returned address
  count_t       count;                  // Free entries in the list
  logic         fill_phase;
  logic         fill_done;
  logic         push;
  logic         fl_push;
  addr_t        fl_din;

  assign fill_phase = (state == ST_FILL);
  assign fill_done  = fill_phase && (count == count_t'(`MEM_NUMADDR - 1));
  assign ready      = (state == ST_RUN);

  // Allocate only with a non-empty list
  assign take = ma_write && ready && (count != '0);
  assign push = dq_vld && ready;

  // During fill the tail pointer itself is the address loaded, giving 0 to 15
  assign fl_push = fill_phase || push;
  assign fl_din  = fill_phase ? tail : dq_adr;

  assign ma_adr = fl_mem[head];         // Head of list shown to the user

  // ******************************
  // Sequence control
  // ******************************
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ST_FILL;
    end else begin
      case (state)
        ST_FILL: if (fill_done) state <= ST_RUN;
        ST_RUN:  state <= ST_RUN;
        default: state <= ST_FILL;
      endcase
    end
  end

  // ******************************
  // Pointers and free count
  // ******************************
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (take) begin
        head <= head + 1'b1;            // Wraps at MEM_NUMADDR
      end
      if (fl_push) begin
        tail <= tail + 1'b1;
      end
      case ({fl_push, take})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;        // Take and push together cancel
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fl_push) begin
      fl_mem[tail] <= fl_din;
    end
  end

  // Advisory back-pressure, one cycle behind the count
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ma_bp <= 1'b0;
    end else begin
      ma_bp <= (count <= bp_thr);
    end
  end

  // ******************************
  // Checks
  // ******************************

  // User must respect an empty list
  a_no_alloc_empty: assert property (@(posedge clk) disable iff (!rst_n)
    (ma_write && ready) |-> (count != '0))
    else $error("ma_write while the free list is empty");

  // A returned address can never overflow the list
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    dq_vld |-> (ready && (count != count_t'(`MEM_NUMADDR))))
    else $error("dq_vld while the free list is full or filling");

endmodule

// File: data_store.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module data_store (
  input  logic                 clk,
  input  logic                 take,
  input  mem_types_pkg::addr_t ma_adr,
  input  mem_types_pkg::data_t ma_din,
  input  logic                 write,
  input  mem_types_pkg::addr_t wr_adr,
  input  mem_types_pkg::data_t din,
  input  logic                 read,
  input  mem_types_pkg::addr_t rd_adr,
  output mem_types_pkg::data_t rd_word
);

  import mem_types_pkg::*;

  data_t mem [`MEM_NUMADDR];            // Payload array

  // ******************************
  // Write side
  // ******************************

  // Plain write comes last so it wins on a shared address
  always_ff @(posedge clk) begin
    if (take) begin
      mem[ma_adr] <= ma_din;            // Data that arrives with the allocate
    end
    if (write) begin
      mem[wr_adr] <= din;
    end
  end

  // ******************************
  // Read side
  // ******************************

  // Sampled before this edge's writes land
  always_ff @(posedge clk) begin
    if (read) begin
      rd_word <= mem[rd_adr];
    end
  end

  // Allocate hands out a free address, the write port should not target it yet
  a_no_take_write_clash: assert property (@(posedge clk)
    (take && write) |-> (ma_adr != wr_adr))
    else $error("allocate and write hit address %0h in one cycle", wr_adr);

endmodule

// File: read_path.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module read_path (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 take,
  input  mem_types_pkg::addr_t ma_adr,
  input  logic                 dq_vld,
  input  mem_types_pkg::addr_t dq_adr,
  input  logic                 read,
  input  mem_types_pkg::addr_t rd_adr,
  input  mem_types_pkg::data_t rd_word,
  output mem_types_pkg::data_t rd_dout,
  output logic                 rd_vld,
  output logic                 rd_err
);

  logic [`MEM_NUMADDR-1:0] alloc_map;   // One bit per address held by the user
  logic                    rd_vld_s1;
  logic                    rd_err_s1;

  // ******************************
  // Allocation map
  // ******************************

  // Take always lands on a free address, so it never meets a dequeue
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      alloc_map <= '0;
    end else begin
      if (dq_vld) begin
        alloc_map[dq_adr] <= 1'b0;
      end
      if (take) begin
        alloc_map[ma_adr] <= 1'b1;
      end
    end
  end

  // ******************************
  // Read pipeline
  // ******************************
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_vld_s1 <= 1'b0;
      rd_err_s1 <= 1'b0;
      rd_vld    <= 1'b0;
      rd_err    <= 1'b0;
    end else begin
      rd_vld_s1 <= read;
      rd_err_s1 <= read && !alloc_map[rd_adr]; // Map state at the request edge
      rd_vld    <= rd_vld_s1;
      rd_err    <= rd_err_s1;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_vld_s1) begin
      rd_dout <= rd_word;               // Word from the store, one cycle old
    end
  end

  a_dq_allocated: assert property (@(posedge clk) disable iff (!rst_n)
    dq_vld |-> alloc_map[dq_adr])
    else $error("dequeue of unallocated address %0h", dq_adr);

  a_err_with_vld: assert property (@(posedge clk) disable iff (!rst_n)
    rd_err |-> rd_vld)
    else $error("rd_err without rd_vld");

endmodule

// File: alloc_mem_top.sv
`timescale 1ns/1ps

module alloc_mem_top (
  input  logic                  clk,
  input  logic                  rst_n,
  output logic                  ready,
  input  logic                  ma_write,
  output mem_types_pkg::addr_t  ma_adr,
  input  mem_types_pkg::data_t  ma_din,
  output logic                  ma_bp,
  input  mem_types_pkg::count_t bp_thr,
  input  logic                  write,
  input  mem_types_pkg::addr_t  wr_adr,
  input  mem_types_pkg::data_t  din,
  input  logic                  read,
  input  mem_types_pkg::addr_t  rd_adr,
  output mem_types_pkg::data_t  rd_dout,
  output logic                  rd_vld,
  output logic                  rd_err,
  input  logic                  dq_vld,
  input  mem_types_pkg::addr_t  dq_adr
);

  import mem_types_pkg::*;

  logic  take;                          // Qualified allocate
  data_t rd_word;                       // Store output into the read pipeline

  free_list_alloc u_alloc (
    .clk      (clk),
    .rst_n    (rst_n),
    .ma_write (ma_write),
    .dq_vld   (dq_vld),
    .dq_adr   (dq_adr),
    .bp_thr   (bp_thr),
    .ready    (ready),
    .ma_bp    (ma_bp),
    .take     (take),
    .ma_adr   (ma_adr)
  );

  data_store u_store (
    .clk     (clk),
    .take    (take),
    .ma_adr  (ma_adr),
    .ma_din  (ma_din),
    .write   (write),
    .wr_adr  (wr_adr),
    .din     (din),
    .read    (read),
    .rd_adr  (rd_adr),
    .rd_word (rd_word)
  );

  read_path u_read (
    .clk     (clk),
    .rst_n   (rst_n),
    .take    (take),
    .ma_adr  (ma_adr),
    .dq_vld  (dq_vld),
    .dq_adr  (dq_adr),
    .read    (read),
    .rd_adr  (rd_adr),
    .rd_word (rd_word),
    .rd_dout (rd_dout),
    .rd_vld  (rd_vld),
    .rd_err  (rd_err)
  );

endmodule

// File: tb_alloc_mem.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module tb_alloc_mem;

  import mem_types_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 16;
  localparam int FILL_CYCLES  = `MEM_NUMADDR;
  localparam int TEST_CYCLES  = 400;
  localparam int MARGIN       = 50;
  localparam int WATCHDOG_NS  =
    (RESET_CYCLES + FILL_CYCLES + TEST_CYCLES + MARGIN) * CLK_PERIOD;

  logic   clk;
  logic   rst_n;
  logic   ready;
  logic   ma_write;
  addr_t  ma_adr;
  data_t  ma_din;
  logic   ma_bp;
  count_t bp_thr;
  logic   write;
  addr_t  wr_adr;
  data_t  din;
  logic   read;
  addr_t  rd_adr;
  data_t  rd_dout;
  logic   rd_vld;
  logic   rd_err;
  logic   dq_vld;
  addr_t  dq_adr;

  logic [15:0] lfsr;                    // Stimulus source

  // ******************************
  // Reference model
  // ******************************
  addr_t                   m_free [$];  // Free list with the head at index 0
  addr_t                   m_held [$];  // Addresses owned by the stimulus
  data_t                   m_data [`MEM_NUMADDR];
  logic [`MEM_NUMADDR-1:0] m_alloc;
  logic [`MEM_NUMADDR-1:0] m_known;     // Written at least once
  int                      m_fill;      // Fill pushes since reset
  logic                    s1_vld;
  logic                    s1_err;
  logic                    s1_known;
  data_t                   s1_data;

  // Expected outputs that change at the same edges as the DUT registers
  logic   exp_ready;
  logic   exp_bp;
  logic   exp_rd_vld;
  logic   exp_rd_err;
  logic   exp_rd_known;
  data_t  exp_rd_dout;
  count_t exp_cnt;
  addr_t  exp_head;

  alloc_mem_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      r    = {r[30:0], lfsr[15]};
      lfsr = {lfsr[14:0], fb};
    end
    return r;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, want);
    $display("Simulation finished: FAIL");
    $fatal(1, "output mismatch");
  endtask

  task automatic clear_inputs();
    ma_write <= 1'b0;
    ma_din   <= '0;
    bp_thr   <= '0;
    write    <= 1'b0;
    wr_adr   <= '0;
    din      <= '0;
    read     <= 1'b0;
    rd_adr   <= '0;
    dq_vld   <= 1'b0;
    dq_adr   <= '0;
  endtask

  // Applies the inputs seen at this edge to the model
  task automatic update_model();
    addr_t a;
    if (!rst_n) begin
      m_free.delete();
      m_held.delete();
      m_alloc = '0;
      m_known = '0;
      m_fill  = 0;
      s1_vld  = 1'b0;
      s1_err  = 1'b0;
      exp_bp       <= 1'b0;
      exp_rd_vld   <= 1'b0;
      exp_rd_err   <= 1'b0;
      exp_rd_known <= 1'b0;
    end else begin
      exp_rd_vld <= s1_vld;
      exp_rd_err <= s1_err;
      if (s1_vld) begin
        exp_rd_dout  <= s1_data;
        exp_rd_known <= s1_known;
      end
      exp_bp <= (count_t'(m_free.size()) <= bp_thr);  // Count before this edge
      s1_vld = read;
      s1_err = read && !m_alloc[rd_adr];
      if (read) begin
        s1_data  = m_data[rd_adr];
        s1_known = m_known[rd_adr];
      end
      if (m_fill < FILL_CYCLES) begin
        m_free.push_back(addr_t'(m_fill));
        m_fill++;
      end else begin
        if (ma_write) begin
          a = m_free.pop_front();
          m_data[a]  = ma_din;
          m_known[a] = 1'b1;
          m_alloc[a] = 1'b1;
          m_held.push_back(a);
        end
        if (dq_vld) begin
          m_free.push_back(dq_adr);     // Freed address joins the tail
          m_alloc[dq_adr] = 1'b0;
          for (int i = 0; i < m_held.size(); i++) begin
            if (m_held[i] == dq_adr) begin
              m_held.delete(i);
              break;
            end
          end
        end
      end
      if (write) begin
        m_data[wr_adr]  = din;
        m_known[wr_adr] = 1'b1;
      end
    end
    exp_ready <= (m_fill == FILL_CYCLES);
    exp_cnt   <= count_t'(m_free.size());
    exp_head  <= (m_free.size() != 0) ? m_free[0] : '0;
  endtask

  // Mixed traffic, then drain to empty, then mostly returns
  task automatic drive_inputs(input int t);
    logic  do_alloc;
    logic  do_dq;
    int    idx;
    addr_t a;
    if (t < 216) begin
      do_alloc = (rand_bits(1) == 32'd1);
      do_dq    = (rand_bits(1) == 32'd1);
    end else if (t < 316) begin
      do_alloc = (rand_bits(3) != 32'd0);
      do_dq    = 1'b0;
    end else begin
      do_alloc = (rand_bits(2) == 32'd0);
      do_dq    = (rand_bits(2) != 32'd0);
    end
    do_alloc = do_alloc && (m_fill == FILL_CYCLES) && (m_free.size() != 0);
    do_dq    = do_dq && (m_held.size() != 0);
    ma_write <= do_alloc;
    ma_din   <= rand_bits(32);
    dq_vld   <= do_dq;
    if (do_dq) begin
      idx = int'(rand_bits(8) % 32'(m_held.size()));
      dq_adr <= m_held[idx];
    end
    bp_thr <= count_t'((t / 24) % (`MEM_NUMADDR + 1));
    a = addr_t'(rand_bits(4));
    if (do_alloc && a == m_free[0]) a = a + 1'b1;  // Keep off the address being taken
    write  <= (rand_bits(2) == 32'd0);
    wr_adr <= a;
    din    <= rand_bits(32);
    read   <= (rand_bits(1) == 32'd1);
    rd_adr <= addr_t'(rand_bits(4));
  endtask

  // ******************************
  // Checks
  // ******************************
  a_ready: assert property (@(posedge clk) disable iff (!rst_n) ready == exp_ready)
    else report_mismatch("ready", 32'(ready), 32'(exp_ready));

  a_head: assert property (@(posedge clk) disable iff (!rst_n)
    (exp_ready && exp_cnt != '0) |-> (ma_adr == exp_head))
    else report_mismatch("ma_adr", 32'(ma_adr), 32'(exp_head));

  a_bp: assert property (@(posedge clk) disable iff (!rst_n) ma_bp == exp_bp)
    else report_mismatch("ma_bp", 32'(ma_bp), 32'(exp_bp));

  a_vld: assert property (@(posedge clk) disable iff (!rst_n) rd_vld == exp_rd_vld)
    else report_mismatch("rd_vld", 32'(rd_vld), 32'(exp_rd_vld));

  a_err: assert property (@(posedge clk) disable iff (!rst_n) rd_err == exp_rd_err)
    else report_mismatch("rd_err", 32'(rd_err), 32'(exp_rd_err));

  a_dout: assert property (@(posedge clk) disable iff (!rst_n)
    (rd_vld && exp_rd_known) |-> (rd_dout == exp_rd_dout))
    else report_mismatch("rd_dout", rd_dout, exp_rd_dout);

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Simulation finished: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    lfsr  = 16'd82;
    rst_n = 1'b0;
    clear_inputs();
    repeat (RESET_CYCLES) begin
      @(posedge clk);
      update_model();
    end
    rst_n <= 1'b1;
    for (int t = 0; t < FILL_CYCLES + TEST_CYCLES; t++) begin
      @(posedge clk);
      update_model();
      drive_inputs(t);
    end
    clear_inputs();
    repeat (3) begin                    // Let the last reads come out
      @(posedge clk);
      update_model();
    end
    @(negedge clk);                     // Checks of the last edge are settled
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+.
mem_types_pkg.sv
mem_ctrl_pkg.sv
free_list_alloc.sv
data_store.sv
read_path.sv
alloc_mem_top.sv
tb_alloc_mem.sv

// File: run_sim.sh
#!/bin/sh
# Build and run with Verilator, the run passes only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/1ps --top-module tb_alloc_mem \
  -f vlog.f -o tb_alloc_mem \
  && ./obj_dir/tb_alloc_mem | tee /dev/stderr | grep -q "Simulation finished: PASS" \
  && echo "run_sim: passed" \
  || { echo "run_sim: failed"; exit 1; }
